// ==== source/exu_pkg.sv ====
package exu_pkg;

  // default datapath width of the core
  parameter int XLEN_DEFAULT = 64;

  // operation group, sits in the low bits of the info word
  typedef enum logic [2:0] {
    NONE = 3'd0,
    ALU  = 3'd1,
    BJP  = 3'd2
  } exu_group_e;

  // one-hot alu operations, top bit is spare
  typedef struct packed {
    logic spare;
    logic op_lui;
    logic op_and;
    logic op_or;
    logic op_sra;
    logic op_srl;
    logic op_xor;
    logic op_sltu;
    logic op_slt;
    logic op_sll;
    logic op_sub;
    logic op_add;
  } alu_ctrl_t;

  // one-hot branch and jump operations
  typedef struct packed {
    logic [3:0] pad;
    logic       op_bgeu;
    logic       op_bltu;
    logic       op_bge;
    logic       op_blt;
    logic       op_bne;
    logic       op_beq;
    logic       op_jalr;
    logic       op_jal;
  } bjp_ctrl_t;

  // same 12 bits, meaning depends on the group
  typedef union packed {
    alu_ctrl_t alu;
    bjp_ctrl_t bjp;
  } exu_op_u;

  typedef struct packed {
    exu_op_u    op;
    exu_group_e grp;
  } exu_info_t;

  typedef enum logic {
    OP1_RS1 = 1'b0,
    OP1_PC  = 1'b1
  } op1_sel_e;

  typedef enum logic [1:0] {
    OP2_RS2  = 2'd0,
    OP2_IMM  = 2'd1,
    OP2_FOUR = 2'd2
  } op2_sel_e;

  // base opcodes handled by the decoder
  parameter logic [6:0] OPC_LUI    = 7'b0110111;
  parameter logic [6:0] OPC_JAL    = 7'b1101111;
  parameter logic [6:0] OPC_JALR   = 7'b1100111;
  parameter logic [6:0] OPC_BRANCH = 7'b1100011;
  parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
  parameter logic [6:0] OPC_OP     = 7'b0110011;
  parameter logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                instr_valid_i,
  input  logic [31:0]         instr_i,
  output exu_pkg::exu_info_t  exu_info_o,
  output logic [4:0]          rs1_idx_o,
  output logic [4:0]          rs2_idx_o,
  output logic [4:0]          rd_idx_o,
  output logic                rd_wr_en_o,
  output logic [31:0]         imm_o,
  output exu_pkg::op1_sel_e   op1_sel_o,
  output exu_pkg::op2_sel_e   op2_sel_o,
  output logic                commit_o,
  output logic                illegal_o,
  output logic                halt_o
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i_type;
  logic [31:0] imm_u_type;
  logic [31:0] imm_b_type;
  logic [31:0] imm_j_type;
  logic        rd_en;
  logic        illegal;
  logic        ebreak;
  logic        op_legal;
  logic        imm_legal;
  logic        halt_q;
  logic        illegal_q;

  // funct3 to one-hot alu bits, alt picks sub and sra
  function automatic exu_pkg::alu_ctrl_t alu_decode(input logic [2:0] f3, input logic alt);
    exu_pkg::alu_ctrl_t ctrl;
    ctrl = '0;
    case (f3)
      3'b000: begin
        ctrl.op_sub = alt;
        ctrl.op_add = ~alt;
      end
      3'b001: ctrl.op_sll = 1'b1;
      3'b010: ctrl.op_slt = 1'b1;
      3'b011: ctrl.op_sltu = 1'b1;
      3'b100: ctrl.op_xor = 1'b1;
      3'b101: begin
        ctrl.op_sra = alt;
        ctrl.op_srl = ~alt;
      end
      3'b110: ctrl.op_or = 1'b1;
      default: ctrl.op_and = 1'b1;
    endcase
    return ctrl;
  endfunction

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign rd_idx_o  = instr_i[11:7];
  assign rs1_idx_o = instr_i[19:15];
  assign rs2_idx_o = instr_i[24:20];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // funct7 0100000 only exists for sub and sra
  assign op_legal = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));

  // rv64 immediate shifts use a 6-bit shamt
  assign imm_legal = (funct3 == 3'b001) ? (instr_i[31:26] == 6'b000000) :
                     (funct3 == 3'b101) ? ((instr_i[31:26] == 6'b000000) ||
                                           (instr_i[31:26] == 6'b010000)) : 1'b1;

  always_comb begin
    exu_info_o = '0;
    imm_o      = imm_i_type;
    op1_sel_o  = exu_pkg::OP1_RS1;
    op2_sel_o  = exu_pkg::OP2_RS2;
    rd_en      = 1'b0;
    illegal    = 1'b0;
    ebreak     = 1'b0;
    case (opcode)
      exu_pkg::OPC_OP: begin
        exu_info_o.grp    = exu_pkg::ALU;
        exu_info_o.op.alu = alu_decode(funct3, instr_i[30]);
        rd_en             = 1'b1;
        illegal           = ~op_legal;
      end
      exu_pkg::OPC_OP_IMM: begin
        exu_info_o.grp    = exu_pkg::ALU;
        exu_info_o.op.alu = alu_decode(funct3, (funct3 == 3'b101) && instr_i[30]);
        op2_sel_o         = exu_pkg::OP2_IMM;
        rd_en             = 1'b1;
        illegal           = ~imm_legal;
      end
      exu_pkg::OPC_LUI: begin
        exu_info_o.grp           = exu_pkg::ALU;
        exu_info_o.op.alu.op_lui = 1'b1;
        imm_o                    = imm_u_type;
        op2_sel_o                = exu_pkg::OP2_IMM;
        rd_en                    = 1'b1;
      end
      exu_pkg::OPC_JAL: begin
        exu_info_o.grp           = exu_pkg::BJP;
        exu_info_o.op.bjp.op_jal = 1'b1;
        imm_o                    = imm_j_type;
        op1_sel_o                = exu_pkg::OP1_PC;
        op2_sel_o                = exu_pkg::OP2_FOUR;
        rd_en                    = 1'b1;
      end
      exu_pkg::OPC_JALR: begin
        exu_info_o.grp            = exu_pkg::BJP;
        exu_info_o.op.bjp.op_jalr = 1'b1;
        op1_sel_o                 = exu_pkg::OP1_PC;
        op2_sel_o                 = exu_pkg::OP2_FOUR;
        rd_en                     = 1'b1;
        illegal                   = (funct3 != 3'b000);
      end
      exu_pkg::OPC_BRANCH: begin
        exu_info_o.grp            = exu_pkg::BJP;
        exu_info_o.op.bjp.op_beq  = (funct3 == 3'b000);
        exu_info_o.op.bjp.op_bne  = (funct3 == 3'b001);
        exu_info_o.op.bjp.op_blt  = (funct3 == 3'b100);
        exu_info_o.op.bjp.op_bge  = (funct3 == 3'b101);
        exu_info_o.op.bjp.op_bltu = (funct3 == 3'b110);
        exu_info_o.op.bjp.op_bgeu = (funct3 == 3'b111);
        imm_o                     = imm_b_type;
        illegal                   = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      exu_pkg::OPC_SYSTEM: begin
        // only ebreak is supported here
        ebreak  = (instr_i == 32'h0010_0073);
        illegal = ~ebreak;
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      exu_info_o = '0;
      rd_en      = 1'b0;
    end
  end

  assign rd_wr_en_o = rd_en && (rd_idx_o != 5'd0);
  assign commit_o   = instr_valid_i && !halt_q;

  // sticky halt and one-cycle illegal pulse
  always_ff @(posedge clk) begin
    if (reset_i) begin
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      illegal_q <= commit_o && illegal;
      if (commit_o && ebreak) begin
        halt_q <= 1'b1;
      end
    end
  end

  assign halt_o    = halt_q;
  assign illegal_o = illegal_q;

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ns

module reg_file #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            we_i,
  input  logic [4:0]      waddr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic [4:0]      raddr1_i,
  input  logic [4:0]      raddr2_i,
  output logic [XLEN-1:0] rdata1_o,
  output logic [XLEN-1:0] rdata2_o
);

  // x0 is not stored
  logic [XLEN-1:0] regs [31:1];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // asynchronous reads
  assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

// ==== source/operand_select.sv ====
`timescale 1ns/1ns

module operand_select #(
  parameter int XLEN = 64
) (
  input  logic              [XLEN-1:0] pc_i,
  input  logic              [XLEN-1:0] rs1_data_i,
  input  logic              [XLEN-1:0] rs2_data_i,
  input  logic              [XLEN-1:0] imm_i,
  input  exu_pkg::op1_sel_e            op1_sel_i,
  input  exu_pkg::op2_sel_e            op2_sel_i,
  input  logic                         is_jalr_i,
  output logic              [XLEN-1:0] op1_o,
  output logic              [XLEN-1:0] op2_o,
  output logic              [XLEN-1:0] jump_base_o
);

  assign op1_o = (op1_sel_i == exu_pkg::OP1_PC) ? pc_i : rs1_data_i;

  always_comb begin
    case (op2_sel_i)
      exu_pkg::OP2_RS2:  op2_o = rs2_data_i;
      exu_pkg::OP2_IMM:  op2_o = imm_i;
      // link value is pc + 4
      exu_pkg::OP2_FOUR: op2_o = XLEN'(4);
      default:           op2_o = '0;
    endcase
  end

  // jalr jumps relative to rs1, everything else to pc
  assign jump_base_o = is_jalr_i ? rs1_data_i : pc_i;

endmodule

// ==== source/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit #(
  parameter int XLEN = 64
) (
  input  exu_pkg::alu_ctrl_t            alu_op_i,
  input  exu_pkg::bjp_ctrl_t            bjp_op_i,
  input  logic               [XLEN-1:0] op1_i,
  input  logic               [XLEN-1:0] op2_i,
  output logic               [XLEN-1:0] res_o,
  output logic                          cmp_eq_o,
  output logic                          cmp_lt_o,
  output logic                          cmp_ltu_o
);

  localparam int SHW = $clog2(XLEN);

  logic            is_branch;
  logic            cmp_unsigned;
  logic            sel_add_sub;
  logic            do_sub;
  logic            ext1;
  logic            ext2;
  logic [XLEN:0]   adder_in1;
  logic [XLEN:0]   adder_in2;
  logic [XLEN:0]   adder_res;
  logic            lt_bit;
  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] slt_res;

  assign is_branch = bjp_op_i.op_beq | bjp_op_i.op_bne | bjp_op_i.op_blt |
                     bjp_op_i.op_bge | bjp_op_i.op_bltu | bjp_op_i.op_bgeu;

  // links go through the adder as pc + 4
  assign sel_add_sub = alu_op_i.op_add | alu_op_i.op_sub | bjp_op_i.op_jal | bjp_op_i.op_jalr;
  assign do_sub      = alu_op_i.op_sub | alu_op_i.op_slt | alu_op_i.op_sltu | is_branch;

  // zero extension turns the top bit into an unsigned borrow
  assign cmp_unsigned = alu_op_i.op_sltu | bjp_op_i.op_bltu | bjp_op_i.op_bgeu;
  assign ext1         = cmp_unsigned ? 1'b0 : op1_i[XLEN-1];
  assign ext2         = cmp_unsigned ? 1'b0 : op2_i[XLEN-1];

  assign adder_in1 = {ext1, op1_i};
  assign adder_in2 = do_sub ? ~{ext2, op2_i} : {ext2, op2_i};
  assign adder_res = adder_in1 + adder_in2 + {{XLEN{1'b0}}, do_sub};

  assign lt_bit    = adder_res[XLEN];
  assign cmp_eq_o  = (adder_res[XLEN-1:0] == '0);
  assign cmp_lt_o  = lt_bit & ~cmp_unsigned;
  assign cmp_ltu_o = lt_bit & cmp_unsigned;

  assign slt_res = {{(XLEN-1){1'b0}}, lt_bit};

  // shifter
  assign shamt   = op2_i[SHW-1:0];
  assign sll_res = op1_i << shamt;
  assign srl_res = op1_i >> shamt;
  assign sra_res = $signed(op1_i) >>> shamt;

  // one-hot and-or result mux
  assign res_o = ({XLEN{sel_add_sub}}                        & adder_res[XLEN-1:0]) |
                 ({XLEN{alu_op_i.op_sll}}                    & sll_res)             |
                 ({XLEN{alu_op_i.op_slt | alu_op_i.op_sltu}} & slt_res)             |
                 ({XLEN{alu_op_i.op_xor}}                    & (op1_i ^ op2_i))     |
                 ({XLEN{alu_op_i.op_srl}}                    & srl_res)             |
                 ({XLEN{alu_op_i.op_sra}}                    & sra_res)             |
                 ({XLEN{alu_op_i.op_or}}                     & (op1_i | op2_i))     |
                 ({XLEN{alu_op_i.op_and}}                    & (op1_i & op2_i))     |
                 ({XLEN{alu_op_i.op_lui}}                    & op2_i);

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit #(
  parameter int XLEN = 64
) (
  input  exu_pkg::bjp_ctrl_t            bjp_op_i,
  input  logic                          is_bjp_i,
  input  logic                          cmp_eq_i,
  input  logic                          cmp_lt_i,
  input  logic                          cmp_ltu_i,
  input  logic               [XLEN-1:0] jump_base_i,
  input  logic               [XLEN-1:0] imm_i,
  output logic                          jump_taken_o,
  output logic               [XLEN-1:0] jump_addr_o
);

  logic            cond_taken;
  logic [XLEN-1:0] target;

  // each branch uses its flag or the inverse
  assign cond_taken = (bjp_op_i.op_beq  &  cmp_eq_i)  |
                      (bjp_op_i.op_bne  & ~cmp_eq_i)  |
                      (bjp_op_i.op_blt  &  cmp_lt_i)  |
                      (bjp_op_i.op_bge  & ~cmp_lt_i)  |
                      (bjp_op_i.op_bltu &  cmp_ltu_i) |
                      (bjp_op_i.op_bgeu & ~cmp_ltu_i);

  assign jump_taken_o = is_bjp_i & (bjp_op_i.op_jal | bjp_op_i.op_jalr | cond_taken);

  // bit 0 cleared, needed for jalr
  assign target      = jump_base_i + imm_i;
  assign jump_addr_o = {target[XLEN-1:1], 1'b0};

endmodule

// ==== source/pc_reg.sv ====
`timescale 1ns/1ns

module pc_reg #(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            commit_i,
  input  logic            jump_taken_i,
  input  logic [XLEN-1:0] jump_addr_i,
  output logic [XLEN-1:0] pc_o
);

  logic [XLEN-1:0] pc_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else if (commit_i) begin
      pc_q <= jump_taken_i ? jump_addr_i : pc_q + XLEN'(4);
    end
  end

  assign pc_o = pc_q;

endmodule

// ==== source/exec_core.sv ====
`timescale 1ns/1ns

module exec_core #(
  parameter int              XLEN     = exu_pkg::XLEN_DEFAULT,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            instr_valid_i,
  input  logic [31:0]     instr_i,
  output logic [XLEN-1:0] pc_o,
  output logic            wb_en_o,
  output logic [4:0]      wb_idx_o,
  output logic [XLEN-1:0] wb_data_o,
  output logic            halt_o,
  output logic            illegal_o
);

  exu_pkg::exu_info_t exu_info;
  exu_pkg::alu_ctrl_t alu_op;
  exu_pkg::bjp_ctrl_t bjp_op;
  exu_pkg::op1_sel_e  op1_sel;
  exu_pkg::op2_sel_e  op2_sel;
  logic [4:0]         rs1_idx;
  logic [4:0]         rs2_idx;
  logic [4:0]         rd_idx;
  logic               rd_wr_en;
  logic [31:0]        imm32;
  logic [XLEN-1:0]    imm;
  logic               commit;
  logic               rd_we;
  logic               is_bjp;
  logic [XLEN-1:0]    rs1_data;
  logic [XLEN-1:0]    rs2_data;
  logic [XLEN-1:0]    op1;
  logic [XLEN-1:0]    op2;
  logic [XLEN-1:0]    jump_base;
  logic [XLEN-1:0]    alu_res;
  logic               cmp_eq;
  logic               cmp_lt;
  logic               cmp_ltu;
  logic               jump_taken;
  logic [XLEN-1:0]    jump_addr;
  logic [XLEN-1:0]    pc;
  logic               wb_en_q;
  logic [4:0]         wb_idx_q;
  logic [XLEN-1:0]    wb_data_q;

  inst_decoder u_decoder (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .exu_info_o    (exu_info),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rd_idx_o      (rd_idx),
    .rd_wr_en_o    (rd_wr_en),
    .imm_o         (imm32),
    .op1_sel_o     (op1_sel),
    .op2_sel_o     (op2_sel),
    .commit_o      (commit),
    .illegal_o     (illegal_o),
    .halt_o        (halt_o)
  );

  // decoder immediates are already sign-extended to 32 bits
  assign imm   = {{(XLEN-32){imm32[31]}}, imm32};
  assign rd_we = commit & rd_wr_en;

  // the shared op word, read per group
  assign is_bjp = (exu_info.grp == exu_pkg::BJP);
  assign alu_op = (exu_info.grp == exu_pkg::ALU) ? exu_info.op.alu : '0;
  assign bjp_op = is_bjp ? exu_info.op.bjp : '0;

  reg_file #(.XLEN(XLEN)) u_reg_file (
    .clk      (clk),
    .reset_i  (reset_i),
    .we_i     (rd_we),
    .waddr_i  (rd_idx),
    .wdata_i  (alu_res),
    .raddr1_i (rs1_idx),
    .raddr2_i (rs2_idx),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  operand_select #(.XLEN(XLEN)) u_operand_select (
    .pc_i        (pc),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .imm_i       (imm),
    .op1_sel_i   (op1_sel),
    .op2_sel_i   (op2_sel),
    .is_jalr_i   (bjp_op.op_jalr),
    .op1_o       (op1),
    .op2_o       (op2),
    .jump_base_o (jump_base)
  );

  alu_unit #(.XLEN(XLEN)) u_alu (
    .alu_op_i  (alu_op),
    .bjp_op_i  (bjp_op),
    .op1_i     (op1),
    .op2_i     (op2),
    .res_o     (alu_res),
    .cmp_eq_o  (cmp_eq),
    .cmp_lt_o  (cmp_lt),
    .cmp_ltu_o (cmp_ltu)
  );

  branch_unit #(.XLEN(XLEN)) u_branch (
    .bjp_op_i     (exu_info.op.bjp),
    .is_bjp_i     (is_bjp),
    .cmp_eq_i     (cmp_eq),
    .cmp_lt_i     (cmp_lt),
    .cmp_ltu_i    (cmp_ltu),
    .jump_base_i  (jump_base),
    .imm_i        (imm),
    .jump_taken_o (jump_taken),
    .jump_addr_o  (jump_addr)
  );

  pc_reg #(.XLEN(XLEN), .RESET_PC(RESET_PC)) u_pc_reg (
    .clk          (clk),
    .reset_i      (reset_i),
    .commit_i     (commit),
    .jump_taken_i (jump_taken),
    .jump_addr_i  (jump_addr),
    .pc_o         (pc)
  );

  // writeback seen one cycle after acceptance
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_en_q <= 1'b0;
    end else begin
      wb_en_q <= rd_we;
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      wb_idx_q  <= rd_idx;
      wb_data_q <= alu_res;
    end
  end

  assign pc_o      = pc;
  assign wb_en_o   = wb_en_q;
  assign wb_idx_o  = wb_idx_q;
  assign wb_data_o = wb_data_q;

endmodule

// ==== tb/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// rv64i opcodes seen by the model
localparam logic [6:0] RV_LUI    = 7'b0110111;
localparam logic [6:0] RV_JAL    = 7'b1101111;
localparam logic [6:0] RV_JALR   = 7'b1100111;
localparam logic [6:0] RV_BRANCH = 7'b1100011;
localparam logic [6:0] RV_OP_IMM = 7'b0010011;
localparam logic [6:0] RV_OP     = 7'b0110011;
localparam logic [6:0] RV_SYSTEM = 7'b1110011;

// architectural state of the model
logic [63:0] m_regs [32];
logic [63:0] m_pc;
logic        m_halt;

// expected outputs one cycle after acceptance
logic        exp_wb_en;
logic [4:0]  exp_wb_idx;
logic [63:0] exp_wb_data;
logic        exp_illegal;

function automatic logic [63:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] x, input logic [63:0] y);
  logic [63:0] r;
  r = '0;
  case (f3)
    3'b000: r = alt ? x - y : x + y;
    3'b001: r = x << y[5:0];
    3'b010: r = {63'b0, ($signed(x) < $signed(y))};
    3'b011: r = {63'b0, (x < y)};
    3'b100: r = x ^ y;
    3'b101: begin
      if (alt) begin
        r = $signed(x) >>> y[5:0];
      end else begin
        r = x >> y[5:0];
      end
    end
    3'b110: r = x | y;
    default: r = x & y;
  endcase
  return r;
endfunction

task automatic model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_pc        = '0;
  m_halt      = 1'b0;
  exp_wb_en   = 1'b0;
  exp_wb_idx  = '0;
  exp_wb_data = '0;
  exp_illegal = 1'b0;
endtask

// cycle without an accepted instruction
task automatic model_idle();
  exp_wb_en   = 1'b0;
  exp_illegal = 1'b0;
endtask

task automatic model_step(input logic [31:0] instr);
  logic [6:0]  opc;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] imm_i;
  logic [63:0] imm_b;
  logic [63:0] imm_j;
  logic [63:0] res;
  logic [63:0] next_pc;
  logic        wr;
  logic        bad;
  logic        take;
  logic        brk;
  opc     = instr[6:0];
  rd      = instr[11:7];
  f3      = instr[14:12];
  rs1     = instr[19:15];
  rs2     = instr[24:20];
  f7      = instr[31:25];
  a       = m_regs[rs1];
  b       = m_regs[rs2];
  imm_i   = {{52{instr[31]}}, instr[31:20]};
  imm_b   = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  imm_j   = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  next_pc = m_pc + 64'd4;
  res     = '0;
  wr      = 1'b0;
  bad     = 1'b0;
  take    = 1'b0;
  brk     = 1'b0;
  model_idle();
  // a halted core ignores everything
  if (!m_halt) begin
    case (opc)
      RV_OP: begin
        wr  = 1'b1;
        bad = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101))));
        res = model_alu(f3, f7[5], a, b);
      end
      RV_OP_IMM: begin
        wr = 1'b1;
        if (f3 == 3'b001) begin
          bad = (instr[31:26] != 6'b000000);
        end else if (f3 == 3'b101) begin
          bad = (instr[31:26] != 6'b000000) && (instr[31:26] != 6'b010000);
        end
        res = model_alu(f3, (f3 == 3'b101) && instr[30], a, imm_i);
      end
      RV_LUI: begin
        wr  = 1'b1;
        res = {{32{instr[31]}}, instr[31:12], 12'b0};
      end
      RV_JAL: begin
        wr      = 1'b1;
        res     = m_pc + 64'd4;
        next_pc = m_pc + imm_j;
      end
      RV_JALR: begin
        wr      = 1'b1;
        bad     = (f3 != 3'b000);
        res     = m_pc + 64'd4;
        next_pc = (a + imm_i) & ~64'd1;
      end
      RV_BRANCH: begin
        case (f3)
          3'b000: take = (a == b);
          3'b001: take = (a != b);
          3'b100: take = ($signed(a) < $signed(b));
          3'b101: take = ($signed(a) >= $signed(b));
          3'b110: take = (a < b);
          3'b111: take = (a >= b);
          default: bad = 1'b1;
        endcase
        if (take) begin
          next_pc = m_pc + imm_b;
        end
      end
      RV_SYSTEM: begin
        brk = (instr == 32'h0010_0073);
        bad = !brk;
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      wr      = 1'b0;
      next_pc = m_pc + 64'd4;
    end
    exp_illegal = bad;
    exp_wb_en   = wr && (rd != 5'd0);
    exp_wb_idx  = rd;
    exp_wb_data = res;
    if (exp_wb_en) begin
      m_regs[rd] = res;
    end
    m_pc = next_pc;
    if (brk) begin
      m_halt = 1'b1;
    end
  end
endtask

`endif

// ==== tb/exec_core_tb.sv ====
`timescale 1ns/1ns

module exec_core_tb;

  localparam logic [31:0] LFSR_SEED  = 32'he13;
  localparam int          N_PRELOAD  = 10;
  localparam int          N_RANDOM   = 400;
  localparam int          N_ILLEGAL  = 4;
  localparam int          N_AFTER    = 4;
  localparam int          N_TOTAL    = N_PRELOAD + N_RANDOM + N_ILLEGAL + 1 + N_AFTER;
  // up to 4 cycles per instruction, plus reset and margin
  localparam int          TIMEOUT_NS = (N_TOTAL * 4 + 20) * 20;

  logic        clk;
  logic        reset_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [63:0] pc_o;
  logic        wb_en_o;
  logic [4:0]  wb_idx_o;
  logic [63:0] wb_data_o;
  logic        halt_o;
  logic        illegal_o;
  logic [31:0] lfsr_state;

  `include "rv_ref_model.svh"

  exec_core #(
    .XLEN     (64),
    .RESET_PC (64'd0)
  ) u_dut (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_o          (pc_o),
    .wb_en_o       (wb_en_o),
    .wb_idx_o      (wb_idx_o),
    .wb_data_o     (wb_data_o),
    .halt_o        (halt_o),
    .illegal_o     (illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before all instructions were checked");
    $display("Simulation failed");
    $fatal(1);
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return val;
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, RV_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, RV_LUI};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], RV_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, RV_JAL};
  endfunction

  // registers limited to x0..x7
  function automatic logic [31:0] gen_random_instr();
    logic [2:0]  cls;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        alt;
    logic [11:0] imm12;
    logic [31:0] instr;
    cls   = 3'(rand_bits(3));
    f3    = 3'(rand_bits(3));
    rd    = {2'b00, 3'(rand_bits(3))};
    rs1   = {2'b00, 3'(rand_bits(3))};
    rs2   = {2'b00, 3'(rand_bits(3))};
    alt   = 1'(rand_bits(1));
    imm12 = 12'(rand_bits(12));
    case (cls)
      3'd0, 3'd1: begin
        instr = enc_r((alt && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00,
                      rs2, rs1, f3, rd);
      end
      3'd2, 3'd3: begin
        // shift amounts reach 63
        if (f3 == 3'b001) begin
          imm12 = {6'b0, imm12[5:0]};
        end else if (f3 == 3'b101) begin
          imm12 = {1'b0, alt, 4'b0, imm12[5:0]};
        end
        instr = enc_i(imm12, rs1, f3, rd, RV_OP_IMM);
      end
      3'd4: instr = enc_u(20'(rand_bits(20)), rd);
      3'd5: begin
        // funct3 2 and 3 are no branch, remap to bltu and bgeu
        if (f3[2:1] == 2'b01) begin
          f3 = {1'b1, f3[1:0]};
        end
        instr = enc_b({imm12, 1'b0}, rs2, rs1, f3);
      end
      3'd6: instr = enc_j({20'(rand_bits(20)), 1'b0}, rd);
      default: instr = enc_i(imm12, rs1, 3'b000, rd, RV_JALR);
    endcase
    return instr;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic compare_outputs();
    check_value("pc_o", pc_o, m_pc);
    check_value("wb_en_o", 64'(wb_en_o), 64'(exp_wb_en));
    if (exp_wb_en) begin
      check_value("wb_idx_o", 64'(wb_idx_o), 64'(exp_wb_idx));
      check_value("wb_data_o", wb_data_o, exp_wb_data);
    end
    check_value("illegal_o", 64'(illegal_o), 64'(exp_illegal));
    check_value("halt_o", 64'(halt_o), 64'(m_halt));
  endtask

  // entered and left 2 ns after a rising edge
  task automatic issue(input logic [31:0] instr);
    int gap;
    gap           = int'(rand_bits(2));
    instr_valid_i = 1'b1;
    instr_i       = instr;
    @(posedge clk);
    #1;
    model_step(instr);
    compare_outputs();
    #1;
    instr_valid_i = 1'b0;
    instr_i       = 32'(rand_bits(32));
    repeat (gap) begin
      @(posedge clk);
      #1;
      model_idle();
      compare_outputs();
      #1;
    end
  endtask

  initial begin
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    lfsr_state    = LFSR_SEED;
    model_reset();
    repeat (4) @(posedge clk);
    #2;
    reset_i = 1'b0;
    compare_outputs();

    // preload with signed values and values near the limits
    issue(enc_u(20'h80000, 5'd1));
    issue(enc_i(12'hfff, 5'd0, 3'b000, 5'd2, RV_OP_IMM));
    issue(enc_i(12'h7ff, 5'd0, 3'b000, 5'd3, RV_OP_IMM));
    issue(enc_i(12'h001, 5'd0, 3'b000, 5'd4, RV_OP_IMM));
    issue(enc_i(12'h03f, 5'd4, 3'b001, 5'd4, RV_OP_IMM));
    issue(enc_i(12'hfff, 5'd4, 3'b000, 5'd5, RV_OP_IMM));
    issue(enc_u(20'(rand_bits(20)), 5'd6));
    issue(enc_i(12'(rand_bits(12)), 5'd6, 3'b000, 5'd6, RV_OP_IMM));
    issue(enc_u(20'(rand_bits(20)), 5'd7));
    issue(enc_i(12'(rand_bits(12)), 5'd7, 3'b000, 5'd7, RV_OP_IMM));

    for (int i = 0; i < N_RANDOM; i++) begin
      issue(gen_random_instr());
    end

    // custom-0 and load opcodes are undefined here
    for (int i = 0; i < N_ILLEGAL; i++) begin
      issue({25'(rand_bits(25)), (i % 2 == 0) ? 7'b0001011 : 7'b0000011});
    end

    // ebreak, then the core must ignore input
    issue(32'h0010_0073);
    for (int i = 0; i < N_AFTER; i++) begin
      issue(gen_random_instr());
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tb
source/exu_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_select.sv
source/alu_unit.sv
source/branch_unit.sv
source/pc_reg.sv
source/exec_core.sv
tb/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - source/exu_pkg.sv
  - source/inst_decoder.sv
  - source/reg_file.sv
  - source/operand_select.sv
  - source/alu_unit.sv
  - source/branch_unit.sv
  - source/pc_reg.sv
  - source/exec_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/exec_core_tb.sv
